// ==== logic/arb_defs.svh ====
// --------------------------------------------------
// arbitration block sizes
// --------------------------------------------------

`ifndef ARB_DEFS_SVH
`define ARB_DEFS_SVH

// number of requestor lanes, power of two (2, 4, 8 or 16)
`define ARB_NUM_REQ 8

// lane index width, log2 of the lane count
`define ARB_SEL_W 3

// request word width
`define ARB_DATA_W 32

`endif

// ==== logic/arb_pkg.sv ====
// --------------------------------------------------
// arbitration types
// --------------------------------------------------

`include "arb_defs.svh"

package arb_pkg;

	// one bit per requestor lane
	// used for push, pending, grant and clear
	typedef logic [`ARB_NUM_REQ-1:0] req_vec_t;

	// lane index
	typedef logic [`ARB_SEL_W-1:0] sel_t;

	// request word as posted by a lane
	typedef logic [`ARB_DATA_W-1:0] data_t;

	// state of one two-input tree node
	// idle means neither side holds the grant
	typedef enum logic [1:0]
	{
		NODE_IDLE   = 2'd0,
		NODE_GRANT0 = 2'd1,
		NODE_GRANT1 = 2'd2
	} node_state_t;

endpackage : arb_pkg

// ==== logic/arbiter_node.sv ====
// --------------------------------------------------
// two-input round-robin node
// --------------------------------------------------

`include "arb_defs.svh"

module arbiter_node (
	input  logic       ap_clk,
	input  logic       areset,
	input  logic       enable,
	input  logic [1:0] req,
	output logic [1:0] grant,
	output logic       select,
	output logic       valid
);

	arb_pkg::node_state_t state;
	arb_pkg::node_state_t state_next;

	// --------------------------------------------------
	// next state
	// --------------------------------------------------
	// a granted side keeps the grant while its request stays up,
	// on release the other side gets its turn
	always_comb
	begin
		case (state)
			arb_pkg::NODE_GRANT0:
			begin
				if (req[0])
					state_next = arb_pkg::NODE_GRANT0;
				else if (req[1])
					state_next = arb_pkg::NODE_GRANT1;
				else
					state_next = arb_pkg::NODE_IDLE;
			end
			arb_pkg::NODE_GRANT1:
			begin
				if (req[1])
					state_next = arb_pkg::NODE_GRANT1;
				else if (req[0])
					state_next = arb_pkg::NODE_GRANT0;
				else
					state_next = arb_pkg::NODE_IDLE;
			end
			default:
			begin
				// from idle, side 0 wins a tie
				if (req[0])
					state_next = arb_pkg::NODE_GRANT0;
				else if (req[1])
					state_next = arb_pkg::NODE_GRANT1;
				else
					state_next = arb_pkg::NODE_IDLE;
			end
		endcase
	end

	always_ff @(posedge ap_clk)
	begin
		if (areset)
			state <= arb_pkg::NODE_IDLE;
		else
			state <= state_next;
	end

	// --------------------------------------------------
	// outputs
	// --------------------------------------------------
	// grant is only passed down when the parent enables this node
	assign grant[0] = enable && (state == arb_pkg::NODE_GRANT0);
	assign grant[1] = enable && (state == arb_pkg::NODE_GRANT1);

	// select tells the parent path which child is being served
	assign select = (state == arb_pkg::NODE_GRANT1);

	// valid goes up the tree as the parent's request
	assign valid = req[0] | req[1];

	a_grant_onehot0 : assert property (@(posedge ap_clk) disable iff (areset)
		$onehot0(grant))
		else $error("arbiter_node: both grant bits high");

endmodule : arbiter_node

// ==== logic/arbiter.sv ====
// --------------------------------------------------
// round-robin arbiter tree
// --------------------------------------------------

`include "arb_defs.svh"

module arbiter #(
	parameter int WIDTH = `ARB_NUM_REQ
) (
	input  logic              ap_clk,
	input  logic              areset,
	input  logic              enable,
	input  arb_pkg::req_vec_t req,
	output arb_pkg::req_vec_t grant,
	output arb_pkg::sel_t     select,
	output logic              valid
);

	// number of tree levels
	localparam int SEL_W = $clog2(WIDTH);

	// tree wiring in heap order
	// node 1 is the root, node n has children 2n and 2n+1,
	// index WIDTH+i is lane i
	logic [2*WIDTH-1:1] node_valid;
	logic [2*WIDTH-1:1] node_en;
	logic [WIDTH-1:1]   node_sel;

	// lane index below each node, built bottom up
	arb_pkg::sel_t node_idx [WIDTH-1:1];

	// the ports carry the package widths, so the tree must match them
	if (WIDTH != `ARB_NUM_REQ)
	begin : gen_width_check
		$error("arbiter: WIDTH must equal ARB_NUM_REQ");
	end

	// leaves are the lane requests, root enable is the outside enable
	assign node_valid[2*WIDTH-1:WIDTH] = req;
	assign node_en[1]                  = enable;

	// --------------------------------------------------
	// node tree and select forwarding
	// --------------------------------------------------
	// level 0 sits right above the lanes, the top level is the root
	for (genvar lv = 0; lv < SEL_W; lv++)
	begin : gen_level
		localparam int FIRST = WIDTH >> (lv + 1);

		for (genvar k = 0; k < FIRST; k++)
		begin : gen_node
			localparam int N = FIRST + k;

			arbiter_node u_node (
				.ap_clk (ap_clk),
				.areset (areset),
				.enable (node_en[N]),
				.req    ({node_valid[2*N+1], node_valid[2*N]}),
				.grant  ({node_en[2*N+1], node_en[2*N]}),
				.select (node_sel[N]),
				.valid  (node_valid[N])
			);

			if (lv == 0)
			begin : gen_leaf_idx
				// lowest level, own select is the lane's low bit
				assign node_idx[N] = arb_pkg::sel_t'(node_sel[N]);
			end
			else
			begin : gen_fwd_idx
				arb_pkg::sel_t child_idx;

				// forward the index of the child this node serves,
				// own select goes on top as the next bit up
				assign child_idx   = node_sel[N] ? node_idx[2*N+1] : node_idx[2*N];
				assign node_idx[N] = arb_pkg::sel_t'({node_sel[N], child_idx[lv-1:0]});
			end
		end
	end

	// --------------------------------------------------
	// output registers
	// --------------------------------------------------
	always_ff @(posedge ap_clk)
	begin
		if (areset)
		begin
			grant  <= '0;
			select <= '0;
			valid  <= 1'b0;
		end
		else
		begin
			grant  <= node_en[2*WIDTH-1:WIDTH];
			select <= node_idx[1];
			valid  <= node_valid[1];
		end
	end

	// at most one lane leaves the tree with a grant
	a_grant_onehot0 : assert property (@(posedge ap_clk) disable iff (areset)
		$onehot0(grant))
		else $error("arbiter: more than one lane granted");

	// forwarded index points at the granted lane
	a_grant_select : assert property (@(posedge ap_clk) disable iff (areset)
		(grant != '0) |-> grant[select])
		else $error("arbiter: grant and select disagree");

endmodule : arbiter

// ==== logic/request_buffer.sv ====
// --------------------------------------------------
// per-lane request buffer
// --------------------------------------------------

`include "arb_defs.svh"

module request_buffer (
	input  logic              ap_clk,
	input  logic              areset,
	input  arb_pkg::req_vec_t push,
	input  arb_pkg::data_t    push_data [`ARB_NUM_REQ],
	input  arb_pkg::req_vec_t clear,
	output arb_pkg::req_vec_t pending,
	output arb_pkg::data_t    data [`ARB_NUM_REQ]
);

	// --------------------------------------------------
	// pending bits
	// --------------------------------------------------
	// a lane only pushes while idle and is only cleared while pending,
	// so push and clear never meet on the same bit
	always_ff @(posedge ap_clk)
	begin
		if (areset)
			pending <= '0;
		else
			pending <= (pending & ~clear) | push;
	end

	// --------------------------------------------------
	// word storage
	// --------------------------------------------------
	// one word per lane, written on its push pulse
	always_ff @(posedge ap_clk)
	begin
		for (int i = 0; i < `ARB_NUM_REQ; i++)
		begin
			if (push[i])
				data[i] <= push_data[i];
		end
	end

	// requestor side protocol
	a_push_idle : assert property (@(posedge ap_clk) disable iff (areset)
		((push & pending) == '0))
		else $error("request_buffer: push to a pending lane");

	// issue side never clears a lane it has not seen pending
	a_clear_pending : assert property (@(posedge ap_clk) disable iff (areset)
		((clear & ~pending) == '0))
		else $error("request_buffer: clear of an idle lane");

endmodule : request_buffer

// ==== logic/request_issue.sv ====
// --------------------------------------------------
// request issue stage
// --------------------------------------------------

`include "arb_defs.svh"

module request_issue (
	input  logic              ap_clk,
	input  logic              areset,
	input  arb_pkg::req_vec_t grant,
	input  arb_pkg::sel_t     select,
	input  logic              valid,
	input  arb_pkg::req_vec_t pending,
	input  arb_pkg::data_t    data [`ARB_NUM_REQ],
	output arb_pkg::req_vec_t clear,
	output logic              out_valid,
	output arb_pkg::sel_t     out_id,
	output arb_pkg::data_t    out_data
);

	logic fire;

	// issue only a granted lane that is still pending
	// the arbiter lags the buffer, so its choice is checked against the live bits
	// a lane whose clear is in flight still reads pending for one cycle
	assign fire = valid && grant[select] && pending[select] && !clear[select];

	// --------------------------------------------------
	// control pulses
	// --------------------------------------------------
	always_ff @(posedge ap_clk)
	begin
		if (areset)
		begin
			out_valid <= 1'b0;
			clear     <= '0;
		end
		else
		begin
			out_valid <= fire;
			clear     <= fire ? (arb_pkg::req_vec_t'(1) << select) : '0;
		end
	end

	// payload, only meaningful with out_valid
	always_ff @(posedge ap_clk)
	begin
		if (fire)
		begin
			out_id   <= select;
			out_data <= data[select];
		end
	end

	a_clear_onehot0 : assert property (@(posedge ap_clk) disable iff (areset)
		$onehot0(clear))
		else $error("request_issue: clear on more than one lane");

endmodule : request_issue

// ==== logic/arb_top.sv ====
// --------------------------------------------------
// request arbitration top
// --------------------------------------------------

`include "arb_defs.svh"

module arb_top (
	input  logic              ap_clk,
	input  logic              areset,
	input  logic              enable,
	input  arb_pkg::req_vec_t push,
	input  arb_pkg::data_t    push_data [`ARB_NUM_REQ],
	output arb_pkg::req_vec_t pending,
	output logic              out_valid,
	output arb_pkg::sel_t     out_id,
	output arb_pkg::data_t    out_data
);

	// buffer contents toward the issue stage
	arb_pkg::data_t    buf_data [`ARB_NUM_REQ];

	// arbiter choice, all registered
	arb_pkg::req_vec_t arb_grant;
	arb_pkg::sel_t     arb_select;
	logic              arb_valid;

	// issued lane back to the buffer
	arb_pkg::req_vec_t issue_clear;

	request_buffer u_buffer (
		.ap_clk    (ap_clk),
		.areset    (areset),
		.push      (push),
		.push_data (push_data),
		.clear     (issue_clear),
		.pending   (pending),
		.data      (buf_data)
	);

	// pending bits are the arbiter's requests
	arbiter #(
		.WIDTH (`ARB_NUM_REQ)
	) u_arbiter (
		.ap_clk (ap_clk),
		.areset (areset),
		.enable (enable),
		.req    (pending),
		.grant  (arb_grant),
		.select (arb_select),
		.valid  (arb_valid)
	);

	request_issue u_issue (
		.ap_clk    (ap_clk),
		.areset    (areset),
		.grant     (arb_grant),
		.select    (arb_select),
		.valid     (arb_valid),
		.pending   (pending),
		.data      (buf_data),
		.clear     (issue_clear),
		.out_valid (out_valid),
		.out_id    (out_id),
		.out_data  (out_data)
	);

endmodule : arb_top

// ==== verif/arb_checker.sv ====
// --------------------------------------------------
// arbitration output checker
// --------------------------------------------------

`include "arb_defs.svh"

module arb_checker (
	input  logic              ap_clk,
	input  logic              areset,
	input  logic              enable,
	input  arb_pkg::req_vec_t push,
	input  arb_pkg::data_t    push_data [`ARB_NUM_REQ],
	input  arb_pkg::req_vec_t pending,
	input  logic              out_valid,
	input  arb_pkg::sel_t     out_id,
	input  arb_pkg::data_t    out_data,
	input  logic              case_done,
	output logic              drained,
	output int                tests_run,
	output int                tests_failed,
	output int                error_count
);

	// name of the running test, written by the testbench top
	string             test_name;
	// last word posted per lane
	arb_pkg::data_t    expected [`ARB_NUM_REQ];
	arb_pkg::req_vec_t outstanding;
	arb_pkg::req_vec_t issued;
	int                test_errors;
	int                low_cycles;
	int                total_tests;
	int                total_failed;
	int                total_errors;

	initial test_name = "reset";

	task automatic record_failure;
		test_errors++;
		total_errors++;
	endtask

	always @(posedge ap_clk)
	begin
		if (areset)
		begin
			outstanding = '0;
			issued = '0;
			test_errors = 0;
			low_cycles = 0;
			total_tests = 0;
			total_failed = 0;
			total_errors = 0;
		end
		else
		begin
			// --------------------------------------------------
			// back-pressure and pending bits
			// --------------------------------------------------
			// three low samples flush the registered grant and the issue stage
			if (enable)
				low_cycles = 0;
			else if (low_cycles < 3)
				low_cycles++;
			if (low_cycles >= 3 && out_valid)
			begin
				$display("test %s: out_valid while enable held low", test_name);
				record_failure();
			end
			// pending must follow posted lanes, sampled before this edge's updates
			if (pending !== outstanding)
			begin
				$display("** Error: test %s pending expected %b actual %b",
					test_name, outstanding, pending);
				record_failure();
			end

			// --------------------------------------------------
			// issued words
			// --------------------------------------------------
			if (out_valid)
			begin
				if (outstanding[out_id])
				begin
					if (out_data !== expected[out_id])
					begin
						$display("** Error: test %s lane %0d expected %h actual %h",
							test_name, out_id, expected[out_id], out_data);
						record_failure();
					end
					outstanding[out_id] = 1'b0;
					issued[out_id] = 1'b1;
				end
				else if (issued[out_id])
				begin
					$display("test %s: lane %0d issued twice", test_name, out_id);
					record_failure();
				end
				else
				begin
					$display("test %s: issue from lane %0d that was never pushed",
						test_name, out_id);
					record_failure();
				end
			end

			// new posts replace the expected word
			for (int i = 0; i < `ARB_NUM_REQ; i++)
			begin
				if (push[i])
				begin
					expected[i] = push_data[i];
					outstanding[i] = 1'b1;
				end
			end

			// end of test, anything still posted was lost
			if (case_done)
			begin
				for (int i = 0; i < `ARB_NUM_REQ; i++)
				begin
					if (outstanding[i])
					begin
						$display("test %s: lane %0d was never issued", test_name, i);
						record_failure();
					end
				end
				total_tests++;
				if (test_errors != 0)
				begin
					total_failed++;
					$display("test %s: failed with %0d errors", test_name, test_errors);
				end
				else
					$display("test %s: passed", test_name);
				test_errors = 0;
				issued = '0;
			end
		end

		drained      <= (outstanding == '0);
		tests_run    <= total_tests;
		tests_failed <= total_failed;
		error_count  <= total_errors;
	end

endmodule : arb_checker

// ==== verif/arb_tb.sv ====
// --------------------------------------------------
// arbitration block testbench
// --------------------------------------------------

`include "arb_defs.svh"

module arb_tb;

	// wait limits in clock cycles
	localparam int ISSUE_LIMIT = 60;
	localparam int DRAIN_LIMIT = 200;

	logic              ap_clk;
	logic              areset;
	logic              enable;
	arb_pkg::req_vec_t push;
	arb_pkg::data_t    push_data [`ARB_NUM_REQ];
	arb_pkg::req_vec_t pending;
	logic              out_valid;
	arb_pkg::sel_t     out_id;
	arb_pkg::data_t    out_data;

	logic case_done;
	logic drained;
	int   tests_run;
	int   tests_failed;
	int   error_count;
	int   seed;

	arb_top dut (
		.ap_clk    (ap_clk),
		.areset    (areset),
		.enable    (enable),
		.push      (push),
		.push_data (push_data),
		.pending   (pending),
		.out_valid (out_valid),
		.out_id    (out_id),
		.out_data  (out_data)
	);

	arb_checker chk (
		.ap_clk       (ap_clk),
		.areset       (areset),
		.enable       (enable),
		.push         (push),
		.push_data    (push_data),
		.pending      (pending),
		.out_valid    (out_valid),
		.out_id       (out_id),
		.out_data     (out_data),
		.case_done    (case_done),
		.drained      (drained),
		.tests_run    (tests_run),
		.tests_failed (tests_failed),
		.error_count  (error_count)
	);

	initial
	begin
		ap_clk = 1'b0;
		forever #50 ap_clk = ~ap_clk;
	end

	// --------------------------------------------------
	// one test: post under back-pressure, release, re-post one lane
	// --------------------------------------------------
	task automatic run_case(input string name, input arb_pkg::req_vec_t mask, input int hold,
		input arb_pkg::data_t base, output bit ok);
		int            cnt;
		int            delay;
		arb_pkg::sel_t lane;
		ok = 1'b1;
		@(posedge ap_clk);
		enable <= 1'b0;
		for (int i = 0; i < `ARB_NUM_REQ; i++)
			push_data[i] <= base + i;
		push <= mask;
		@(posedge ap_clk);
		push <= '0;
		repeat (hold) @(posedge ap_clk);
		enable <= 1'b1;
		// first issue picks the lane that is posted again
		cnt = 0;
		do
		begin
			@(posedge ap_clk);
			cnt++;
		end while (!out_valid && cnt < ISSUE_LIMIT);
		if (!out_valid)
		begin
			$display("test %s: timed out waiting for the first issue", name);
			ok = 1'b0;
			return;
		end
		lane = out_id;
		cnt = 0;
		do
		begin
			@(posedge ap_clk);
			cnt++;
		end while (pending[lane] && cnt < ISSUE_LIMIT);
		if (pending[lane])
		begin
			$display("test %s: lane %0d stayed pending after its issue", name, lane);
			ok = 1'b0;
			return;
		end
		// short random gap so the re-post can meet a stale grant
		delay = $random(seed) & 3;
		repeat (delay) @(posedge ap_clk);
		@(posedge ap_clk);
		push_data[lane] <= base + 32'h0080_0000 + 32'(lane);
		push <= arb_pkg::req_vec_t'(1) << lane;
		@(posedge ap_clk);
		push <= '0;
		cnt = 0;
		do
		begin
			@(posedge ap_clk);
			cnt++;
		end while (!(pending == '0 && drained) && cnt < DRAIN_LIMIT);
		if (!(pending == '0 && drained))
		begin
			$display("test %s: timed out waiting for the lanes to drain", name);
			ok = 1'b0;
		end
	endtask

	// end-of-test strobe, plus one edge so the checker's counts settle
	task automatic signal_case_end;
		@(posedge ap_clk);
		case_done <= 1'b1;
		@(posedge ap_clk);
		case_done <= 1'b0;
		@(posedge ap_clk);
	endtask

	initial
	begin
		int                fd;
		string             line;
		string             name;
		arb_pkg::req_vec_t mask;
		int                hold;
		arb_pkg::data_t    base;
		bit                ok;
		bit                aborted;
		areset = 1'b1;
		enable = 1'b0;
		push = '0;
		for (int i = 0; i < `ARB_NUM_REQ; i++)
			push_data[i] = '0;
		case_done = 1'b0;
		seed = 32'ha3e0;
		aborted = 1'b0;
		repeat (16) @(posedge ap_clk);
		areset <= 1'b0;
		// idle stretch after reset, nothing may show up here
		repeat (8) @(posedge ap_clk);
		fd = $fopen("verif/arb_cases.txt", "r");
		if (fd == 0)
		begin
			$display("could not open verif/arb_cases.txt");
			aborted = 1'b1;
		end
		while (!aborted && $fgets(line, fd) != 0)
		begin
			if ($sscanf(line, "%s %h %d %h", name, mask, hold, base) == 4
				&& name.getc(0) != "#")
			begin
				// name switches after the checker has sampled this edge
				chk.test_name <= name;
				run_case(name, mask, hold, base, ok);
				if (!ok)
					aborted = 1'b1;
				signal_case_end();
			end
		end
		if (fd != 0)
			$fclose(fd);
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (!aborted && tests_run > 0 && tests_failed == 0 && error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule : arb_tb

// ==== verif/arb_cases.txt ====
# lines: test name, push mask (hex), enable hold cycles, data base (hex)
# one test per line, fields split by spaces
single_lane0 01 2 a0000000
single_lane5 20 3 a1000000
single_lane7 80 0 a2000000
all_lanes ff 2 b0000000
hold_even 55 12 c0000000
hold_odd aa 20 c1000000
hold_all ff 40 c2000000
upper_half f0 4 d0000000
pair_edges 81 1 e0000000
low_pair 03 6 f0000000

// ==== vlog.f ====
+incdir+logic
logic/arb_pkg.sv
logic/arbiter_node.sv
logic/arbiter.sv
logic/request_buffer.sv
logic/request_issue.sv
logic/arb_top.sv
verif/arb_checker.sv
verif/arb_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the arbitration testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module arb_tb -f vlog.f -o arb_sim

status=0
out=$(./obj_dir/arb_sim 2>&1) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1
